/* Bender.yml */
package:
  name: x86_length_decoder

sources:
  - verilog/x86_isa_pkg.sv
  - verilog/byte_stream_pkg.sv
  - verilog/byte_window_if.sv
  - verilog/fetch_queue.sv
  - verilog/prefix_scanner.sv
  - verilog/opcode_length_decoder.sv
  - verilog/instr_assembler.sv
  - verilog/x86_length_decoder.sv
  - target: test
    files:
      - test/x86_length_decoder_props.sv
      - test/tb_x86_length_decoder.sv

/* test/tb_x86_length_decoder.sv */
`timescale 1ns/1ps

module tb_x86_length_decoder;
    import byte_stream_pkg::*;
    import x86_isa_pkg::*;

    localparam int QUEUE_WORDS = 6;
    localparam int N_INSTR = 500;
    localparam logic [39:0] ALU_BASES = 40'h00_20_28_30_38;  // add, and, sub, xor, cmp

    typedef enum int {
        rule_w_bit,
        rule_byte,
        rule_wide
    } size_rule_t;

    typedef struct packed {
        addr_t         addr;
        instr_len_t    len;
        prefix_count_t pcount;
        op_class_t     cls;
        op_size_t      osize;
    } record_t;

    logic          i_clk = 1'b0;
    logic          i_reset;
    logic          i_word_valid;
    word_t         i_word;
    logic          o_word_credit;
    logic          o_instr_valid;
    logic          i_instr_ready;
    addr_t         o_instr_addr;
    instr_len_t    o_instr_len;
    prefix_count_t o_prefix_count;
    op_class_t     o_op_class;
    op_size_t      o_op_size;

    integer  seed = 32'hfbb6;
    byte_t   stream_q[$];
    word_t   word_q[$];
    record_t exp_q[$];
    addr_t   next_addr;
    int      n_words = 0;
    int      n_records = 0;
    int      checked = 0;
    int      errors = 0;

    always #2 i_clk = ~i_clk;

    x86_length_decoder #(
        .QUEUE_WORDS(QUEUE_WORDS)
    ) x86_length_decoder_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_word_valid   (i_word_valid),
        .i_word         (i_word),
        .o_word_credit  (o_word_credit),
        .o_instr_valid  (o_instr_valid),
        .i_instr_ready  (i_instr_ready),
        .o_instr_addr   (o_instr_addr),
        .o_instr_len    (o_instr_len),
        .o_prefix_count (o_prefix_count),
        .o_op_class     (o_op_class),
        .o_op_size      (o_op_size)
    );

    bind x86_length_decoder x86_length_decoder_props #(
        .QUEUE_WORDS(QUEUE_WORDS)
    ) props_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_word_valid   (i_word_valid),
        .o_word_credit  (o_word_credit),
        .o_instr_valid  (o_instr_valid),
        .i_instr_ready  (i_instr_ready),
        .o_instr_addr   (o_instr_addr),
        .o_instr_len    (o_instr_len),
        .o_prefix_count (o_prefix_count),
        .o_op_class     (o_op_class),
        .o_op_size      (o_op_size)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic byte_t rand_byte();
        return byte_t'(rand_below(256));
    endfunction

    // Byte k of the list, lowest byte first
    function automatic byte_t pick(input logic [63:0] list, input int n);
        return list[8 * rand_below(n) +: 8];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    task automatic push_record(input int len, input int pcount, input op_class_t cls,
                               input op_size_t osize);
        record_t rec;
        rec.addr = next_addr;
        rec.len = instr_len_t'(len);
        rec.pcount = prefix_count_t'(pcount);
        rec.cls = cls;
        rec.osize = osize;
        exp_q.push_back(rec);
        next_addr = next_addr + addr_t'(len);
    endtask

    task automatic add_instruction();
        byte_t      bytes[$];
        byte_t      op;
        byte_t      modrm;
        byte_t      sib;
        logic       opsz;
        logic       has_modrm;
        int         imm;
        int         disp;
        int         n_pre;
        op_class_t  cls;
        size_rule_t rule;
        op_size_t   osize;

        has_modrm = 1'b0;
        imm = 0;
        rule = rule_wide;
        // Prefixes in slot order
        if (rand_below(4) == 0) bytes.push_back(8'hf0);
        if (rand_below(4) == 0) bytes.push_back(pick(16'hf2_f3, 2));
        if (rand_below(4) == 0) bytes.push_back(pick(48'h26_2e_36_3e_64_65, 6));
        opsz = (rand_below(3) == 0);
        if (opsz) bytes.push_back(8'h66);
        if (rand_below(4) == 0) bytes.push_back(8'h67);
        n_pre = bytes.size();
        case (rand_below(14))
            0: begin
                op = pick(ALU_BASES, 5) + byte_t'(rand_below(4));
                cls = op_alu;
                rule = rule_w_bit;
                has_modrm = 1'b1;
            end
            1: begin
                op = pick(ALU_BASES, 5) + 8'h04;
                cls = op_alu;
                rule = rule_byte;
                imm = 1;
            end
            2: begin
                op = pick(ALU_BASES, 5) + 8'h05;
                cls = op_alu;
                imm = opsz ? 2 : 4;
            end
            3: begin
                op = pick(24'h80_81_83, 3);
                cls = op_alu_imm;
                rule = rule_w_bit;
                has_modrm = 1'b1;
                imm = (op == 8'h81) ? (opsz ? 2 : 4) : 1;
            end
            4: begin
                op = 8'h88 + byte_t'(rand_below(4));
                cls = op_mov;
                rule = rule_w_bit;
                has_modrm = 1'b1;
            end
            5: begin
                op = pick(16'hc6_c7, 2);
                cls = op_mov;
                rule = rule_w_bit;
                has_modrm = 1'b1;
                imm = (op == 8'hc7) ? (opsz ? 2 : 4) : 1;
            end
            6: begin
                op = 8'ha0 + byte_t'(rand_below(4));  // moffs stays 32-bit
                cls = op_mov;
                rule = rule_w_bit;
                imm = 4;
            end
            7: begin
                op = 8'hb0 + byte_t'(rand_below(16));
                cls = op_mov;
                rule = (op < 8'hb8) ? rule_byte : rule_wide;
                imm = (op < 8'hb8) ? 1 : (opsz ? 2 : 4);
            end
            8: begin
                op = pick(24'h8d_8c_8e, 3);
                cls = (op == 8'h8d) ? op_lea : op_mov;
                has_modrm = 1'b1;
            end
            9: begin
                op = pick(40'h86_87_fe_f6_f7, 5);
                if (op == 8'hfe) cls = op_dec;
                else if (op >= 8'hf6) cls = op_div;
                else cls = op_xchg;
                rule = rule_w_bit;
                has_modrm = 1'b1;
            end
            10: begin
                op = pick(24'h90_50_58, 3) + byte_t'(rand_below(8));
                if (op >= 8'h90) cls = op_xchg;
                else if (op >= 8'h58) cls = op_pop;
                else cls = op_push;
            end
            11: begin
                op = pick(24'he8_e9_eb, 3);
                cls = (op == 8'he8) ? op_call : op_jmp;
                imm = (op == 8'heb) ? 1 : 4;
            end
            12: begin
                op = pick(40'hc3_cb_c2_ca_f4, 5);
                cls = (op == 8'hf4) ? op_hlt : op_ret;
                imm = (op == 8'hc2 || op == 8'hca) ? 2 : 0;
            end
            default: begin
                op = pick(16'h0f_cc, 2);
                cls = op_unknown;
            end
        endcase
        bytes.push_back(op);
        if (has_modrm) begin
            modrm = rand_byte();
            if (rand_below(3) == 0) modrm[2:0] = 3'b100;  // Bias toward SIB forms
            sib = rand_byte();
            if (rand_below(3) == 0) sib[2:0] = 3'b101;
            bytes.push_back(modrm);
            disp = (modrm[7:6] == 2'b01) ? 1 : (modrm[7:6] == 2'b10) ? 4 : 0;
            if (modrm[7:6] != 2'b11 && modrm[2:0] == 3'b100) begin
                bytes.push_back(sib);
                if (modrm[7:6] == 2'b00 && sib[2:0] == 3'b101) disp = 4;
            end
            if (modrm[7:6] == 2'b00 && modrm[2:0] == 3'b101) disp = 4;
            imm = imm + disp;
        end
        repeat (imm) bytes.push_back(rand_byte());
        if (rule == rule_byte || (rule == rule_w_bit && !op[0])) osize = size_8;
        else osize = opsz ? size_16 : size_32;
        push_record(bytes.size(), n_pre, cls, osize);
        foreach (bytes[i]) stream_q.push_back(bytes[i]);
    endtask

    task automatic build_stream();
        addr_t start;
        start = addr_t'($random(seed));
        next_addr = start;
        repeat (N_INSTR) add_instruction();
        while (stream_q.size() % 4 != 0) begin  // hlt padding
            stream_q.push_back(8'hf4);
            push_record(1, 0, op_hlt, size_32);
        end
        word_q.push_back(start);
        for (int i = 0; i < stream_q.size(); i += 4) begin
            word_q.push_back({stream_q[i + 3], stream_q[i + 2], stream_q[i + 1], stream_q[i]});
        end
        n_records = exp_q.size();
        n_words = word_q.size();
    endtask

    task automatic check_record();
        record_t rec;
        if (exp_q.size() == 0) begin
            $display("Error at %0t ns: a record arrived when none was expected", $time);
            errors++;
        end else begin
            rec = exp_q.pop_front();
            check_value("o_instr_addr", rec.addr, o_instr_addr);
            check_value("o_instr_len", 32'(rec.len), 32'(o_instr_len));
            check_value("o_prefix_count", 32'(rec.pcount), 32'(o_prefix_count));
            check_value("o_op_class", 32'(rec.cls), 32'(o_op_class));
            check_value("o_op_size", 32'(rec.osize), 32'(o_op_size));
            checked++;
        end
    endtask

    task automatic run_traffic();
        int credits;
        int widx;
        credits = QUEUE_WORDS;
        widx = 0;
        while (widx < n_words || checked < n_records) begin
            @(posedge i_clk);
            if (o_word_credit) begin
                credits++;
            end
            if (credits > QUEUE_WORDS) begin
                $display("Error at %0t ns: more credits returned than words sent", $time);
                errors++;
            end
            if (o_instr_valid && i_instr_ready) begin
                check_record();
            end
            if (widx < n_words && credits > 0 && rand_below(4) != 0) begin
                i_word_valid <= 1'b1;
                i_word <= word_q[widx];
                widx++;
                credits--;
            end else begin
                i_word_valid <= 1'b0;
            end
            i_instr_ready <= (rand_below(4) != 0);  // Random back-pressure
        end
    endtask

    initial begin
        i_reset = 1'b1;
        i_word_valid = 1'b0;
        i_word = '0;
        i_instr_ready = 1'b0;
        build_stream();
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        run_traffic();
        i_instr_ready <= 1'b1;
        repeat (20) begin
            @(posedge i_clk);
            if (o_instr_valid) begin
                $display("Error at %0t ns: a record appeared after the stream ended", $time);
                errors++;
            end
        end
        $display("Records checked: %0d of %0d, errors: %0d, assertion failures: %0d",
                 checked, n_records, errors, x86_length_decoder_i.props_i.fail_count);
        if (errors == 0 && x86_length_decoder_i.props_i.fail_count == 0
            && checked == n_records) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // 50 cycles per generated word
    initial begin
        wait (n_words > 0);
        repeat (n_words * 50) @(posedge i_clk);
        $display("Timeout: the stream did not finish within %0d cycles", n_words * 50);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* test/x86_length_decoder_props.sv */
`timescale 1ns/1ps

module x86_length_decoder_props #(
    parameter int QUEUE_WORDS = 6
) (
    input logic                           i_clk,
    input logic                           i_reset,
    input logic                           i_word_valid,
    input logic                           o_word_credit,
    input logic                           o_instr_valid,
    input logic                           i_instr_ready,
    input byte_stream_pkg::addr_t         o_instr_addr,
    input byte_stream_pkg::instr_len_t    o_instr_len,
    input byte_stream_pkg::prefix_count_t o_prefix_count,
    input x86_isa_pkg::op_class_t         o_op_class,
    input x86_isa_pkg::op_size_t          o_op_size
);

    int          credits_held;   // Credits the sender still holds
    int          fail_count = 0;
    logic [45:0] record;

    assign record = {o_instr_addr, o_instr_len, o_prefix_count, o_op_class, o_op_size};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            credits_held <= QUEUE_WORDS;
        end else begin
            credits_held <= credits_held + int'(o_word_credit) - int'(i_word_valid);
        end
    end

    a_word_has_credit: assert property (@(posedge i_clk) disable iff (i_reset)
        i_word_valid |-> credits_held > 0)
        else begin
            $error("word sent without a credit");
            fail_count++;
        end

    a_credit_bound: assert property (@(posedge i_clk) disable iff (i_reset)
        credits_held <= QUEUE_WORDS)
        else begin
            $error("outstanding credits went negative");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge i_clk)
        i_reset |=> !o_instr_valid && !o_word_credit)
        else begin
            $error("valid or credit high after reset");
            fail_count++;
        end

    a_record_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        o_instr_valid && !i_instr_ready |=> o_instr_valid && $stable(record))
        else begin
            $error("record changed while stalled");
            fail_count++;
        end

endmodule

/* verilog.f */
verilog/x86_isa_pkg.sv
verilog/byte_stream_pkg.sv
verilog/byte_window_if.sv
verilog/fetch_queue.sv
verilog/prefix_scanner.sv
verilog/opcode_length_decoder.sv
verilog/instr_assembler.sv
verilog/x86_length_decoder.sv
test/x86_length_decoder_props.sv
test/tb_x86_length_decoder.sv

/* verilog/byte_stream_pkg.sv */
package byte_stream_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  instr_len_t;     // 1 to 16
    typedef logic [5:0]  byte_count_t;
    typedef logic [2:0]  prefix_count_t;

    // Longest legal x86 instruction
    localparam int WINDOW_BYTES = 16;

    // Lock, rep, segment, operand size, address size
    localparam int MAX_PREFIX = 5;

endpackage

/* verilog/byte_window_if.sv */
`timescale 1ns/1ps

interface byte_window_if;
    import byte_stream_pkg::*;
    import x86_isa_pkg::*;

    byte_t [WINDOW_BYTES-1:0] window;  // Byte 0 is the head
    byte_count_t              count;
    addr_t                    start_addr;
    logic                     start_seen;
    logic                     pop;
    instr_len_t               pop_len;

    modport queue (output window, count, start_addr, start_seen, input pop, pop_len);
    modport scan (input window);
    modport assemble (input window, count, start_addr, start_seen, output pop, pop_len);

endinterface

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_WORDS = 6
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_word_valid,
    input  byte_stream_pkg::word_t i_word,
    output logic                   o_word_credit,
    byte_window_if.queue           win
);
    import byte_stream_pkg::*;
    import x86_isa_pkg::*;

    localparam int QUEUE_BYTES = QUEUE_WORDS * 4;
    localparam int OWED_BITS = $clog2(QUEUE_WORDS + 1) + 1;

    typedef enum logic {
        await_start,
        stream
    } state_t;

    state_t               state;
    byte_t                bytes_q [QUEUE_BYTES];
    byte_t                bytes_d [QUEUE_BYTES];
    byte_count_t          count_q;
    byte_count_t          kept;          // Bytes left after this cycle's pop
    instr_len_t           shift;
    logic                 start_take;
    logic                 append;
    logic [1:0]           pop_frac;      // Popped bytes short of a whole slot
    logic [4:0]           frac_sum;
    logic [OWED_BITS-1:0] credits_owed;

    assign start_take = i_word_valid && (state == await_start);
    assign append = i_word_valid && (state == stream);

    always_comb begin
        shift = '0;
        if (win.pop) begin
            shift = win.pop_len;
        end
        kept = count_q - byte_count_t'(shift);
        frac_sum = {3'b000, pop_frac} + shift;
        for (int i = 0; i < QUEUE_BYTES; i++) begin
            bytes_d[i] = bytes_q[i];
            if (i + int'(shift) < QUEUE_BYTES) begin
                bytes_d[i] = bytes_q[i + int'(shift)];
            end
            // New word lands right behind the bytes still held
            if (append && i >= int'(kept) && i < int'(kept) + 4) begin
                bytes_d[i] = i_word[8 * (i - int'(kept)) +: 8];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= await_start;
            count_q <= '0;
            pop_frac <= '0;
            credits_owed <= '0;
            o_word_credit <= 1'b0;
        end else begin
            if (start_take) begin
                state <= stream;
            end
            count_q <= kept + (append ? byte_count_t'(4) : byte_count_t'(0));
            pop_frac <= frac_sum[1:0];
            o_word_credit <= (credits_owed != 0);  // One credit per cycle at most
            credits_owed <= credits_owed + OWED_BITS'(frac_sum[4:2])
                + OWED_BITS'(start_take) - OWED_BITS'(credits_owed != 0);
        end
    end

    always_ff @(posedge i_clk) begin
        bytes_q <= bytes_d;
        if (start_take) begin
            win.start_addr <= i_word;
        end
    end

    always_comb begin
        for (int k = 0; k < WINDOW_BYTES; k++) begin
            win.window[k] = bytes_q[k];
        end
    end

    assign win.count = count_q;
    assign win.start_seen = (state == stream);

endmodule

/* verilog/instr_assembler.sv */
`timescale 1ns/1ps

module instr_assembler (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    byte_window_if.assemble                      win,
    input  byte_stream_pkg::prefix_count_t       i_prefix_count,
    input  logic                                 i_opsize_override,
    input  x86_isa_pkg::op_class_t               i_op_class [byte_stream_pkg::MAX_PREFIX+1],
    input  x86_isa_pkg::size_kind_t              i_size_kind [byte_stream_pkg::MAX_PREFIX+1],
    input  logic [byte_stream_pkg::MAX_PREFIX:0] i_w_bit,
    input  byte_stream_pkg::instr_len_t          i_body_len [byte_stream_pkg::MAX_PREFIX+1],
    input  x86_isa_pkg::imm_kind_t               i_imm_kind [byte_stream_pkg::MAX_PREFIX+1],
    output logic                                 o_instr_valid,
    input  logic                                 i_instr_ready,
    output byte_stream_pkg::addr_t               o_instr_addr,
    output byte_stream_pkg::instr_len_t          o_instr_len,
    output byte_stream_pkg::prefix_count_t       o_prefix_count,
    output x86_isa_pkg::op_class_t               o_op_class,
    output x86_isa_pkg::op_size_t                o_op_size
);
    import byte_stream_pkg::*;
    import x86_isa_pkg::*;

    instr_len_t imm_len;
    instr_len_t len;
    op_size_t   op_size;
    addr_t      next_addr;
    logic       addr_live;   // Start address loaded
    logic       fire;

    // The decoder whose offset equals the prefix count sees the real opcode
    always_comb begin
        imm_len = '0;
        if (i_imm_kind[i_prefix_count] == imm_opsize) begin
            imm_len = i_opsize_override ? 5'd2 : 5'd4;
        end
        len = instr_len_t'(i_prefix_count) + i_body_len[i_prefix_count] + imm_len;
        if (i_size_kind[i_prefix_count] == sk_byte ||
            (i_size_kind[i_prefix_count] == sk_w_bit && !i_w_bit[i_prefix_count])) begin
            op_size = size_8;
        end else if (i_opsize_override) begin
            op_size = size_16;
        end else begin
            op_size = size_32;
        end
    end

    assign fire = addr_live && (win.count >= byte_count_t'(len))
        && (!o_instr_valid || i_instr_ready);
    assign win.pop = fire;
    assign win.pop_len = len;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_instr_valid <= 1'b0;
            addr_live <= 1'b0;
        end else begin
            if (!addr_live) begin
                addr_live <= win.start_seen;
            end
            if (fire) begin
                o_instr_valid <= 1'b1;
            end else if (i_instr_ready) begin
                o_instr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!addr_live) begin
            next_addr <= win.start_addr;
        end else if (fire) begin
            next_addr <= next_addr + addr_t'(len);
        end
        if (fire) begin
            o_instr_addr <= next_addr;
            o_instr_len <= len;
            o_prefix_count <= i_prefix_count;
            o_op_class <= i_op_class[i_prefix_count];
            o_op_size <= op_size;
        end
    end

endmodule

/* verilog/opcode_length_decoder.sv */
`timescale 1ns/1ps

module opcode_length_decoder (
    input  x86_isa_pkg::byte_t [6:0]    i_bytes,
    output x86_isa_pkg::op_class_t      o_op_class,
    output x86_isa_pkg::size_kind_t     o_size_kind,
    output logic                        o_w_bit,
    output byte_stream_pkg::instr_len_t o_body_len,
    output x86_isa_pkg::imm_kind_t      o_imm_kind
);
    import byte_stream_pkg::*;
    import x86_isa_pkg::*;

    byte_t      opcode;
    byte_t      modrm;
    byte_t      sib;
    logic       has_modrm;
    instr_len_t modrm_len;    // ModRM plus SIB plus displacement
    instr_len_t fixed_len;

    assign opcode = i_bytes[0];
    assign modrm = i_bytes[1];
    assign sib = i_bytes[2];
    assign o_w_bit = opcode[0];

    always_comb begin
        o_op_class = op_unknown;  // Covers 0f too
        o_size_kind = sk_override;
        o_imm_kind = imm_none;
        has_modrm = 1'b0;
        fixed_len = '0;
        case (opcode) inside
            [8'h00:8'h03], [8'h20:8'h23], [8'h28:8'h2b], [8'h30:8'h33], [8'h38:8'h3b]: begin
                o_op_class = op_alu;
                o_size_kind = sk_w_bit;
                has_modrm = 1'b1;
            end
            8'h04, 8'h24, 8'h2c, 8'h34, 8'h3c: begin  // al, imm8
                o_op_class = op_alu;
                o_size_kind = sk_byte;
                o_imm_kind = imm_fixed;
                fixed_len = 5'd1;
            end
            8'h05, 8'h25, 8'h2d, 8'h35, 8'h3d: begin
                o_op_class = op_alu;
                o_imm_kind = imm_opsize;
            end
            8'h80, 8'h83: begin  // 83 sign-extends its imm8
                o_op_class = op_alu_imm;
                o_size_kind = sk_w_bit;
                o_imm_kind = imm_fixed;
                has_modrm = 1'b1;
                fixed_len = 5'd1;
            end
            8'h81: begin
                o_op_class = op_alu_imm;
                o_imm_kind = imm_opsize;
                has_modrm = 1'b1;
            end
            [8'h88:8'h8b], 8'hc6: begin
                o_op_class = op_mov;
                o_size_kind = sk_w_bit;
                has_modrm = 1'b1;
                if (opcode == 8'hc6) begin
                    o_imm_kind = imm_fixed;
                    fixed_len = 5'd1;
                end
            end
            8'h8c, 8'h8e: begin  // Segment register moves
                o_op_class = op_mov;
                has_modrm = 1'b1;
            end
            8'hc7: begin
                o_op_class = op_mov;
                o_imm_kind = imm_opsize;
                has_modrm = 1'b1;
            end
            [8'ha0:8'ha3]: begin  // moffs32
                o_op_class = op_mov;
                o_size_kind = sk_w_bit;
                o_imm_kind = imm_fixed;
                fixed_len = 5'd4;
            end
            [8'hb0:8'hb7]: begin
                o_op_class = op_mov;
                o_size_kind = sk_byte;
                o_imm_kind = imm_fixed;
                fixed_len = 5'd1;
            end
            [8'hb8:8'hbf]: begin
                o_op_class = op_mov;
                o_imm_kind = imm_opsize;
            end
            8'h8d: begin
                o_op_class = op_lea;
                has_modrm = 1'b1;
            end
            8'h86, 8'h87, 8'hfe, 8'hf6, 8'hf7: begin
                o_op_class = (opcode == 8'hfe) ? op_dec :
                             (opcode[7:4] == 4'hf) ? op_div : op_xchg;
                o_size_kind = sk_w_bit;
                has_modrm = 1'b1;
            end
            [8'h90:8'h97]: o_op_class = op_xchg;
            [8'h50:8'h57]: o_op_class = op_push;
            [8'h58:8'h5f]: o_op_class = op_pop;
            8'he8, 8'he9, 8'heb: begin  // Relative targets
                o_op_class = (opcode == 8'he8) ? op_call : op_jmp;
                o_imm_kind = imm_fixed;
                fixed_len = (opcode == 8'heb) ? 5'd1 : 5'd4;
            end
            8'hc2, 8'hca: begin
                o_op_class = op_ret;
                o_imm_kind = imm_fixed;
                fixed_len = 5'd2;
            end
            8'hc3, 8'hcb: o_op_class = op_ret;
            8'hf4: o_op_class = op_hlt;
            default: ;
        endcase
    end

    // 32-bit addressing forms
    always_comb begin
        modrm_len = 5'd1;
        case (modrm[7:6])
            2'b00: begin
                if (modrm[2:0] == 3'b101) begin
                    modrm_len = 5'd5;  // disp32 with no base
                end else if (modrm[2:0] == 3'b100) begin
                    modrm_len = (sib[2:0] == 3'b101) ? 5'd6 : 5'd2;
                end
            end
            2'b01: modrm_len = (modrm[2:0] == 3'b100) ? 5'd3 : 5'd2;
            2'b10: modrm_len = (modrm[2:0] == 3'b100) ? 5'd6 : 5'd5;
            default: ;
        endcase
    end

    assign o_body_len = 5'd1 + (has_modrm ? modrm_len : 5'd0) + fixed_len;

endmodule

/* verilog/prefix_scanner.sv */
`timescale 1ns/1ps

module prefix_scanner (
    byte_window_if.scan                    win,
    output byte_stream_pkg::prefix_count_t o_prefix_count,
    output logic                           o_opsize_override
);
    import byte_stream_pkg::*;
    import x86_isa_pkg::*;

    prefix_count_t pos;
    logic          opsize;

    function automatic logic slot_match(input int slot, input byte_t b);
        case (slot)
            0: return b == 8'hf0;                                          // Lock
            1: return b inside {8'hf2, 8'hf3};                             // Repne, rep
            2: return b inside {8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65}; // Segment
            3: return b == 8'h66;
            default: return b == 8'h67;
        endcase
    endfunction

    // Each slot is tried once, at the byte after the last match
    always_comb begin
        pos = '0;
        opsize = 1'b0;
        for (int slot = 0; slot < MAX_PREFIX; slot++) begin
            if (slot_match(slot, win.window[pos])) begin
                if (slot == 3) begin
                    opsize = 1'b1;
                end
                pos = pos + 1'b1;
            end
        end
    end

    assign o_prefix_count = pos;
    assign o_opsize_override = opsize;

endmodule

/* verilog/x86_isa_pkg.sv */
package x86_isa_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [3:0] {
        op_alu,       // Two-operand ALU forms and accumulator forms
        op_alu_imm,   // 80/81/83 group
        op_mov,
        op_lea,
        op_xchg,
        op_push,
        op_pop,
        op_dec,
        op_div,
        op_call,
        op_jmp,
        op_ret,
        op_hlt,
        op_unknown
    } op_class_t;

    typedef enum logic [1:0] {
        size_8,
        size_16,
        size_32
    } op_size_t;

    typedef enum logic [1:0] {
        imm_none,
        imm_fixed,    // Already counted in the body length
        imm_opsize    // 2 or 4 bytes, set by the 66 prefix
    } imm_kind_t;

    typedef enum logic [1:0] {
        sk_w_bit,     // 8 bits when opcode bit 0 is clear
        sk_byte,
        sk_override   // 16 with a 66 prefix, else 32
    } size_kind_t;

endpackage

/* verilog/x86_length_decoder.sv */
`timescale 1ns/1ps

module x86_length_decoder #(
    parameter int QUEUE_WORDS = 6
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_word_valid,
    input  byte_stream_pkg::word_t         i_word,
    output logic                           o_word_credit,
    output logic                           o_instr_valid,
    input  logic                           i_instr_ready,
    output byte_stream_pkg::addr_t         o_instr_addr,
    output byte_stream_pkg::instr_len_t    o_instr_len,
    output byte_stream_pkg::prefix_count_t o_prefix_count,
    output x86_isa_pkg::op_class_t         o_op_class,
    output x86_isa_pkg::op_size_t          o_op_size
);
    import byte_stream_pkg::*;
    import x86_isa_pkg::*;

    prefix_count_t         prefix_count;
    logic                  opsize_override;
    op_class_t             dec_op_class [MAX_PREFIX+1];
    size_kind_t            dec_size_kind [MAX_PREFIX+1];
    logic [MAX_PREFIX:0]   dec_w_bit;
    instr_len_t            dec_body_len [MAX_PREFIX+1];
    imm_kind_t             dec_imm_kind [MAX_PREFIX+1];

    byte_window_if win_if ();

    fetch_queue #(
        .QUEUE_WORDS(QUEUE_WORDS)
    ) fetch_queue_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_word_valid  (i_word_valid),
        .i_word        (i_word),
        .o_word_credit (o_word_credit),
        .win           (win_if.queue)
    );

    prefix_scanner prefix_scanner_i (
        .win               (win_if.scan),
        .o_prefix_count    (prefix_count),
        .o_opsize_override (opsize_override)
    );

    // One decoder per possible prefix count
    for (genvar g = 0; g <= MAX_PREFIX; g++) begin : g_decoder
        opcode_length_decoder opcode_length_decoder_i (
            .i_bytes     (win_if.window[g +: 7]),
            .o_op_class  (dec_op_class[g]),
            .o_size_kind (dec_size_kind[g]),
            .o_w_bit     (dec_w_bit[g]),
            .o_body_len  (dec_body_len[g]),
            .o_imm_kind  (dec_imm_kind[g])
        );
    end

    instr_assembler instr_assembler_i (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .win               (win_if.assemble),
        .i_prefix_count    (prefix_count),
        .i_opsize_override (opsize_override),
        .i_op_class        (dec_op_class),
        .i_size_kind       (dec_size_kind),
        .i_w_bit           (dec_w_bit),
        .i_body_len        (dec_body_len),
        .i_imm_kind        (dec_imm_kind),
        .o_instr_valid     (o_instr_valid),
        .i_instr_ready     (i_instr_ready),
        .o_instr_addr      (o_instr_addr),
        .o_instr_len       (o_instr_len),
        .o_prefix_count    (o_prefix_count),
        .o_op_class        (o_op_class),
        .o_op_size         (o_op_size)
    );

endmodule
